/* test/posMapTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posMap_defines.svh"

module posMapTb;

    localparam int timeoutCycles = 40;
    localparam int tagLsb        = `LOG_LEAVES_IN_BLOCK + `LOG_PLB_LINES;
    localparam int lineCount     = 1 << `LOG_PLB_LINES;

    logic                    Clock;
    logic                    arstN;
    logic                    CmdValid;
    logic [1:0]              Cmd;
    logic [`ADDR_WIDTH-1:0]  AddrIn;
    logic                    DInValid;
    posMapPkg::plbBlock_t    DIn;
    logic                    OutReady;
    logic                    CmdReady;
    logic                    Valid;
    logic                    Hit;
    logic                    UnInit;
    logic [`LEAF_WIDTH-1:0]  OldLeafOut;
    logic [`LEAF_WIDTH-1:0]  NewLeafOut;
    logic                    Evict;
    logic [`ADDR_WIDTH-1:0]  AddrOut;
    logic                    EvictDataOutValid;
    posMapPkg::plbBlock_t    EvictDataOut;

    // ============================================================
    // Reference model
    // ============================================================
    logic [`ENTRY_WIDTH-1:0]         ramModel [1 << `LOG_FINAL_POSMAP_ENTRIES];
    logic [lineCount-1:0]            lineValid;
    logic [`ADDR_WIDTH-tagLsb-1:0]   lineTag   [lineCount];
    posMapPkg::plbBlock_t            lineBlock [lineCount];
    logic [`LEAF_WIDTH-1:0]          lastNewLeaf;      // NewLeafOut moves only on Update
    logic [31:0]                     lfsrState;
    int                              checkCount;
    int                              errorCount;
    int                              timeoutCount;

    posMapTop uut (
        .Clock             (Clock),
        .arstN             (arstN),
        .CmdValid          (CmdValid),
        .Cmd               (Cmd),
        .AddrIn            (AddrIn),
        .DInValid          (DInValid),
        .DIn               (DIn),
        .OutReady          (OutReady),
        .CmdReady          (CmdReady),
        .Valid             (Valid),
        .Hit               (Hit),
        .UnInit            (UnInit),
        .OldLeafOut        (OldLeafOut),
        .NewLeafOut        (NewLeafOut),
        .Evict             (Evict),
        .AddrOut           (AddrOut),
        .EvictDataOutValid (EvictDataOutValid),
        .EvictDataOut      (EvictDataOut)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [35:0] randomBits(input int nBits);
        logic [35:0] value;
        logic        feedback;
        int          i;
        value = '0;
        for (i = 0; i < nBits; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value     = {value[34:0], feedback};
        end
        return value;
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input logic [35:0] expected, input logic [35:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("ERROR %s: %s expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic waitCmdReady(input string testName);
        int cycles;
        cycles = 0;
        while (CmdReady !== 1'b1 && cycles < timeoutCycles) begin
            @(posedge Clock);
            #1;
            cycles++;
        end
        assert (CmdReady === 1'b1) else begin
            timeoutCount++;
            $display("Timeout in %s: the DUT never became ready for a command", testName);
        end
    endtask

    task automatic waitValid(input string testName, output int cycles);
        cycles = 0;
        while (Valid !== 1'b1 && cycles < timeoutCycles) begin
            @(posedge Clock);
            #1;
            cycles++;
        end
        assert (Valid === 1'b1) else begin
            timeoutCount++;
            $display("Timeout in %s: no result came back from the DUT", testName);
        end
    endtask

    // Sends one command, waits for its result and checks the latency
    task automatic issueCommand(input string testName, input logic [1:0] cmdCode,
                                input logic [`ADDR_WIDTH-1:0] addr,
                                input posMapPkg::plbBlock_t block, input int dataDelay);
        int cycles;
        waitCmdReady(testName);
        CmdValid = 1'b1;
        Cmd      = cmdCode;
        AddrIn   = addr;
        DIn      = block;
        DInValid = (cmdCode == `CMD_REFILL) && (dataDelay == 0);
        @(posedge Clock);
        #1;
        CmdValid = 1'b0;
        DInValid = 1'b0;
        checkValue(testName, "CmdReady after accept", 1'b0, CmdReady);
        if (cmdCode == `CMD_REFILL && dataDelay > 0) begin
            repeat (dataDelay - 1) @(posedge Clock);
            #1;
            DInValid = 1'b1;                              // Late data beat
            @(posedge Clock);
            #1;
            DInValid = 1'b0;
        end
        waitValid(testName, cycles);
        checkValue(testName, "latency", 2, cycles);
    endtask

    task automatic completeHandshake(input string testName);
        OutReady = 1'b1;
        @(posedge Clock);
        #1;
        OutReady = 1'b0;
        checkValue(testName, "Valid after handshake", 1'b0, Valid);
        checkValue(testName, "CmdReady after handshake", 1'b1, CmdReady);
        checkValue(testName, "EvictDataOutValid after handshake", 1'b0, EvictDataOutValid);
    endtask

    task automatic compareResult(input string testName, input logic [1:0] cmdCode,
                                 input logic expHit, input logic [`ENTRY_WIDTH-1:0] expEntry,
                                 input logic expEvict, input logic [`ADDR_WIDTH-1:0] expAddr,
                                 input posMapPkg::plbBlock_t expData);
        checkValue(testName, "Hit", expHit, Hit);
        checkValue(testName, "UnInit", expHit && !expEntry[`ENTRY_WIDTH-1], UnInit);
        if (expHit && expEntry[`ENTRY_WIDTH-1]) begin
            checkValue(testName, "OldLeafOut", expEntry[`LEAF_WIDTH-1:0], OldLeafOut);
        end
        checkValue(testName, "Evict", expEvict, Evict);
        if (expEvict) begin
            checkValue(testName, "AddrOut", expAddr, AddrOut);
            checkValue(testName, "EvictDataOut", expData.raw, EvictDataOut.raw);
        end
        if (cmdCode != `CMD_UPDATE) begin
            checkValue(testName, "NewLeafOut", lastNewLeaf, NewLeafOut);
        end
    endtask

    // One full command against the model, with an optional output stall
    task automatic runCommand(input string testName, input logic [1:0] cmdCode,
                              input logic [`ADDR_WIDTH-1:0] addr, input int dataDelay,
                              input int stallCycles);
        posMapPkg::plbBlock_t            block;
        posMapPkg::plbBlock_t            expData;
        logic [`LOG_PLB_LINES-1:0]       line;
        logic [`LOG_LEAVES_IN_BLOCK-1:0] ent;
        logic [`ADDR_WIDTH-tagLsb-1:0]   tag;
        logic [`ENTRY_WIDTH-1:0]         expEntry;
        logic [`ADDR_WIDTH-1:0]          expAddr;
        logic                            isRefill;
        logic                            onChip;
        logic                            expHit;
        logic                            expEvict;
        int                              idx;
        block.raw = (cmdCode == `CMD_REFILL) ? randomBits(`BLOCK_WIDTH) : '0;
        isRefill  = (cmdCode == `CMD_REFILL) || (cmdCode == `CMD_INIT_REFILL);
        onChip    = !isRefill && (addr >= `FINAL_POSMAP_START);
        ent       = addr[`LOG_LEAVES_IN_BLOCK-1:0];
        line      = addr[tagLsb-1:`LOG_LEAVES_IN_BLOCK];
        tag       = addr[`ADDR_WIDTH-1:tagLsb];
        idx       = 0;
        if (onChip) begin
            idx      = int'(addr - `FINAL_POSMAP_START);
            expHit   = 1'b1;
            expEntry = ramModel[idx];
        end else begin
            expHit   = !isRefill && lineValid[line] && (lineTag[line] == tag);
            expEntry = lineBlock[line].entries[ent];
        end
        expEvict = isRefill && lineValid[line] && (lineTag[line] != tag);
        expAddr  = {lineTag[line], line, {`LOG_LEAVES_IN_BLOCK{1'b0}}};
        expData  = lineBlock[line];

        issueCommand(testName, cmdCode, addr, block, dataDelay);
        compareResult(testName, cmdCode, expHit, expEntry, expEvict, expAddr, expData);
        checkValue(testName, "EvictDataOutValid", expEvict, EvictDataOutValid);
        repeat (stallCycles) begin
            @(posedge Clock);
            #1;
            checkValue(testName, "Valid during stall", 1'b1, Valid);
            checkValue(testName, "CmdReady during stall", 1'b0, CmdReady);
            checkValue(testName, "EvictDataOutValid during stall", 1'b0, EvictDataOutValid);
        end
        if (stallCycles > 0) begin
            compareResult(testName, cmdCode, expHit, expEntry, expEvict, expAddr, expData);
        end

        if (cmdCode == `CMD_UPDATE) begin
            lastNewLeaf = NewLeafOut;
            if (onChip) begin
                ramModel[idx] = {1'b1, NewLeafOut};
            end else if (expHit) begin
                lineBlock[line].entries[ent] = {1'b1, NewLeafOut};
            end
        end else if (isRefill) begin
            lineValid[line] = 1'b1;
            lineTag[line]   = tag;
            lineBlock[line] = block;                      // All zeros for InitRefill
        end
        completeHandshake(testName);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic resetStateTest();
        checkValue("resetState", "CmdReady", 1'b1, CmdReady);
        checkValue("resetState", "Valid", 1'b0, Valid);
        checkValue("resetState", "EvictDataOutValid", 1'b0, EvictDataOutValid);
        runCommand("resetState", `CMD_READ, 10'h3C0, 0, 0);
    endtask

    task automatic onChipUpdateTest();
        runCommand("onChipUpdate", `CMD_UPDATE, 10'h3C5, 0, 0);
        runCommand("onChipUpdate", `CMD_READ, 10'h3C5, 0, 0);
        runCommand("onChipUpdate", `CMD_UPDATE, 10'h3C5, 0, 0);
    endtask

    task automatic plbMissTest();
        runCommand("plbMiss", `CMD_READ, 10'h045, 0, 0);
        runCommand("plbMiss", `CMD_UPDATE, 10'h045, 0, 0);
        runCommand("plbMiss", `CMD_READ, 10'h045, 0, 0);
    endtask

    task automatic refillHitTest();
        int i;
        runCommand("refillHit", `CMD_REFILL, 10'h044, 3, 0);
        for (i = 0; i < 4; i++) begin
            runCommand("refillHit", `CMD_READ, 10'h044 + i, 0, 0);
        end
        runCommand("refillHit", `CMD_UPDATE, 10'h046, 0, 0);
        runCommand("refillHit", `CMD_READ, 10'h046, 0, 0);
    endtask

    task automatic evictInitTest();
        int i;
        runCommand("evictInit", `CMD_REFILL, 10'h064, 0, 0);   // Same line, other tag
        runCommand("evictInit", `CMD_INIT_REFILL, 10'h1A8, 0, 0);
        for (i = 0; i < 4; i++) begin
            runCommand("evictInit", `CMD_READ, 10'h1A8 + i, 0, 0);
        end
        runCommand("evictInit", `CMD_INIT_REFILL, 10'h0A4, 0, 0);
    endtask

    task automatic backPressureTest();
        logic [1:0]             cmds  [7];
        logic [`ADDR_WIDTH-1:0] addrs [7];
        int                     i;
        cmds  = '{`CMD_READ, `CMD_UPDATE, `CMD_READ, `CMD_READ, `CMD_UPDATE, `CMD_READ,
                  `CMD_REFILL};
        addrs = '{10'h3C5, 10'h3C5, 10'h3C5, 10'h0A6, 10'h0A6, 10'h0A6, 10'h0C4};
        for (i = 0; i < 7; i++) begin
            runCommand("backPressure", cmds[i], addrs[i], 2, int'(randomBits(3)) + 1);
        end
    endtask

    initial begin
        int i;
        lfsrState    = 32'h90c8;
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        arstN        = 1'b1;
        CmdValid     = 1'b0;
        Cmd          = `CMD_READ;
        AddrIn       = '0;
        DInValid     = 1'b0;
        DIn          = '0;
        OutReady     = 1'b0;
        lineValid    = '0;
        for (i = 0; i < (1 << `LOG_FINAL_POSMAP_ENTRIES); i++) begin
            ramModel[i] = '0;                             // Whole map uninitialized
        end

        #2 arstN = 1'b0;                                  // Clean falling edge
        repeat (8) @(posedge Clock);
        #1;
        arstN = 1'b1;

        resetStateTest();
        onChipUpdateTest();
        plbMissTest();
        refillHitTest();
        evictInitTest();
        backPressureTest();

        $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/posMap_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posMap_defines.svh"

module posMap_checker (
    input wire                       Clock,
    input wire                       arstN,
    input wire                       Valid,
    input wire                       OutReady,
    input wire                       CmdReady,
    input wire                       Hit,
    input wire                       UnInit,
    input wire [`LEAF_WIDTH-1:0]     OldLeafOut,
    input wire [`LEAF_WIDTH-1:0]     NewLeafOut,
    input wire                       Evict,
    input wire [`ADDR_WIDTH-1:0]     AddrOut,
    input wire                       EvictDataOutValid,
    input wire posMapPkg::plbBlock_t EvictDataOut
);

    // Result held under back-pressure
    resultHeld: assert property (@(posedge Clock) disable iff (!arstN)
        (Valid && !OutReady) |=> $stable({Valid, Hit, UnInit, OldLeafOut, NewLeafOut,
                                          Evict, AddrOut, EvictDataOut}))
        else $error("Result outputs changed while stalled");

    busyWhileValid: assert property (@(posedge Clock) disable iff (!arstN)
        Valid |-> !CmdReady)
        else $error("CmdReady high while a result is pending");

    evictPulse: assert property (@(posedge Clock) disable iff (!arstN)
        EvictDataOutValid |-> (Valid && Evict))
        else $error("EvictDataOutValid without Valid and Evict");

    resetQuiet: assert property (@(posedge Clock) !arstN |-> !Valid)
        else $error("Valid high during reset");

endmodule

bind posMapPlb posMap_checker protocolCheck (
    .Clock             (Clock),
    .arstN             (arstN),
    .Valid             (Valid),
    .OutReady          (OutReady),
    .CmdReady          (CmdReady),
    .Hit               (Hit),
    .UnInit            (UnInit),
    .OldLeafOut        (OldLeafOut),
    .NewLeafOut        (NewLeafOut),
    .Evict             (Evict),
    .AddrOut           (AddrOut),
    .EvictDataOutValid (EvictDataOutValid),
    .EvictDataOut      (EvictDataOut)
);

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/posMapPkg.sv
verilog/leafRng.sv
verilog/posMapRam.sv
verilog/plbCache.sv
verilog/posMapPlb.sv
verilog/posMapTop.sv
test/posMap_checker.sv
test/posMapTb.sv

/* verilog/leafRng.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posMap_defines.svh"

module leafRng (
    input  wire                    Clock,
    input  wire                    arstN,
    input  wire                    LeafTake,
    output logic [`LEAF_WIDTH-1:0] Leaf
);

    localparam logic [15:0] seedValue = 16'hACE1;

    logic [15:0] lfsrState;
    logic        feedback;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    assign feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            lfsrState <= seedValue;
        end else if (LeafTake) begin
            lfsrState <= {lfsrState[14:0], feedback};   // One step per leaf taken
        end
    end

    assign Leaf = lfsrState[`LEAF_WIDTH-1:0];

endmodule

`default_nettype wire

/* verilog/plbCache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posMap_defines.svh"

module plbCache (
    input  wire                       Clock,
    input  wire                       arstN,
    input  wire                       Enable,
    input  wire [1:0]                 Cmd,
    input  wire [`ADDR_WIDTH-1:0]     Addr,
    input  wire posMapPkg::plbBlock_t BlockIn,
    input  wire [`LEAF_WIDTH-1:0]     LeafIn,
    output logic                      RespValid,
    output logic                      Hit,
    output logic [`ENTRY_WIDTH-1:0]   EntryOut,
    output logic                      Evict,
    output logic [`ADDR_WIDTH-1:0]    EvictAddr,
    output posMapPkg::plbBlock_t      EvictBlock
);

    localparam int lineCount = 1 << `LOG_PLB_LINES;
    localparam int tagLsb    = `LOG_LEAVES_IN_BLOCK + `LOG_PLB_LINES;
    localparam int tagWidth  = `ADDR_WIDTH - tagLsb;

    // ============================================================
    // Line storage
    // ============================================================
    logic [lineCount-1:0]   validBits;                   // Cleared by reset
    logic [tagWidth-1:0]    tagMem   [lineCount];
    posMapPkg::plbBlock_t   blockMem [lineCount];

    // ============================================================
    // Address decode and lookup
    // ============================================================
    logic [`LOG_LEAVES_IN_BLOCK-1:0] entryIdx;
    logic [`LOG_PLB_LINES-1:0]       lineIdx;
    logic [tagWidth-1:0]             addrTag;
    logic [tagWidth-1:0]             lineTag;
    posMapPkg::plbBlock_t            lineBlock;
    logic                            lineValid;
    logic                            tagMatch;
    logic                            isRefill;
    logic                            lookupHit;

    assign entryIdx  = Addr[`LOG_LEAVES_IN_BLOCK-1:0];
    assign lineIdx   = Addr[tagLsb-1:`LOG_LEAVES_IN_BLOCK];
    assign addrTag   = Addr[`ADDR_WIDTH-1:tagLsb];

    assign lineTag   = tagMem[lineIdx];
    assign lineBlock = blockMem[lineIdx];
    assign lineValid = validBits[lineIdx];
    assign tagMatch  = lineTag == addrTag;

    assign isRefill  = (Cmd == `CMD_REFILL) || (Cmd == `CMD_INIT_REFILL);
    assign lookupHit = lineValid && tagMatch;

    // ============================================================
    // Control state
    // ============================================================
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            RespValid <= 1'b0;
            validBits <= '0;
        end else begin
            RespValid <= Enable;
            if (Enable && isRefill) begin
                validBits[lineIdx] <= 1'b1;              // Line holds the new block
            end
        end
    end

    // ============================================================
    // Lookup results and block writes
    // ============================================================
    always_ff @(posedge Clock) begin
        if (Enable) begin
            EntryOut   <= lineBlock.entries[entryIdx];
            EvictBlock <= lineBlock;
            if (isRefill) begin
                Hit        <= 1'b0;
                // Only a valid block of another tag is displaced
                Evict      <= lineValid && !tagMatch;
                EvictAddr  <= {lineTag, lineIdx, {`LOG_LEAVES_IN_BLOCK{1'b0}}};

                tagMem[lineIdx] <= addrTag;
                if (Cmd == `CMD_REFILL) begin
                    blockMem[lineIdx].raw <= BlockIn.raw;
                end else begin
                    blockMem[lineIdx].raw <= '0;         // Every entry uninitialized
                end
            end else begin
                Hit        <= lookupHit;
                Evict      <= 1'b0;
                EvictAddr  <= Addr;

                // Update hit rewrites the one entry with the new leaf
                if (Cmd == `CMD_UPDATE && lookupHit) begin
                    blockMem[lineIdx].entries[entryIdx] <= {1'b1, LeafIn};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/posMapPkg.sv */
`default_nettype none

`include "posMap_defines.svh"

package posMapPkg;

    // One PLB block word
    // raw is the refill / evict view, entries is the per-leaf view
    typedef union packed {
        logic [`BLOCK_WIDTH-1:0] raw;
        logic [(1 << `LOG_LEAVES_IN_BLOCK)-1:0][`ENTRY_WIDTH-1:0] entries;
    } plbBlock_t;

endpackage

`default_nettype wire

/* verilog/posMapPlb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posMap_defines.svh"

module posMapPlb (
    input  wire                       Clock,
    input  wire                       arstN,
    input  wire                       CmdValid,
    input  wire [1:0]                 Cmd,
    input  wire [`ADDR_WIDTH-1:0]     AddrIn,
    input  wire                       DInValid,
    input  wire posMapPkg::plbBlock_t DIn,
    input  wire                       OutReady,
    input  wire [`LEAF_WIDTH-1:0]     NewLeaf,
    output logic                      CmdReady,
    output logic                      LeafTake,
    output logic                      Valid,
    output logic                      Hit,
    output logic                      UnInit,
    output logic [`LEAF_WIDTH-1:0]    OldLeafOut,
    output logic [`LEAF_WIDTH-1:0]    NewLeafOut,
    output logic                      Evict,
    output logic [`ADDR_WIDTH-1:0]    AddrOut,
    output logic                      EvictDataOutValid,
    output posMapPkg::plbBlock_t      EvictDataOut
);

    localparam logic [2:0] stateIdle     = 3'd0;
    localparam logic [2:0] stateWaitData = 3'd1;     // Refill waiting for DInValid
    localparam logic [2:0] stateIssue    = 3'd2;     // One-cycle store enable
    localparam logic [2:0] stateWaitResp = 3'd3;
    localparam logic [2:0] stateHold     = 3'd4;     // Result presented

    logic [2:0]               state;
    logic [1:0]               cmdReg;
    logic [`ADDR_WIDTH-1:0]   addrReg;
    posMapPkg::plbBlock_t     blockReg;

    logic                     accept;
    logic                     takeData;
    logic                     ramSelect;
    logic                     respValid;
    logic                     captureResult;

    // ============================================================
    // Command intake
    // ============================================================
    assign CmdReady = state == stateIdle;
    assign accept   = CmdValid && CmdReady;
    assign takeData = DInValid && ((accept && Cmd == `CMD_REFILL) || state == stateWaitData);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state <= stateIdle;
        end else begin
            case (state)
                stateIdle: begin
                    if (accept) begin
                        if (Cmd == `CMD_REFILL && !DInValid) begin
                            state <= stateWaitData;
                        end else begin
                            state <= stateIssue;
                        end
                    end
                end
                stateWaitData: if (DInValid) state <= stateIssue;
                stateIssue:    state <= stateWaitResp;
                stateWaitResp: if (respValid) state <= stateHold;
                stateHold:     if (OutReady) state <= stateIdle;
                default:       state <= stateIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (accept) begin
            cmdReg  <= Cmd;
            addrReg <= AddrIn;
        end
        if (takeData) begin
            blockReg <= DIn;
        end
    end

    // Read and Update of the top region go to the on-chip map
    assign ramSelect = (addrReg >= `FINAL_POSMAP_START) &&
                       (cmdReg == `CMD_READ || cmdReg == `CMD_UPDATE);

    // ============================================================
    // Stores
    // ============================================================
    logic                                 ramEnable;
    logic                                 ramRespValid;
    logic [`ADDR_WIDTH-1:0]               ramOffset;
    logic [`ENTRY_WIDTH-1:0]              ramEntry;
    logic                                 plbEnable;
    logic                                 plbRespValid;
    logic                                 plbHit;
    logic [`ENTRY_WIDTH-1:0]              plbEntry;
    logic                                 plbEvict;
    logic [`ADDR_WIDTH-1:0]               plbEvictAddr;
    posMapPkg::plbBlock_t                 plbEvictBlock;

    assign ramEnable = state == stateIssue && ramSelect;
    assign plbEnable = state == stateIssue && !ramSelect;
    assign ramOffset = addrReg - `FINAL_POSMAP_START;

    posMapRam ram (
        .Clock     (Clock),
        .arstN     (arstN),
        .Enable    (ramEnable),
        .Write     (cmdReg == `CMD_UPDATE),
        .Addr      (ramOffset[`LOG_FINAL_POSMAP_ENTRIES-1:0]),
        .LeafIn    (NewLeaf),
        .RespValid (ramRespValid),
        .EntryOut  (ramEntry)
    );

    plbCache plb (
        .Clock      (Clock),
        .arstN      (arstN),
        .Enable     (plbEnable),
        .Cmd        (cmdReg),
        .Addr       (addrReg),
        .BlockIn    (blockReg),
        .LeafIn     (NewLeaf),
        .RespValid  (plbRespValid),
        .Hit        (plbHit),
        .EntryOut   (plbEntry),
        .Evict      (plbEvict),
        .EvictAddr  (plbEvictAddr),
        .EvictBlock (plbEvictBlock)
    );

    // ============================================================
    // Result registers
    // ============================================================
    assign respValid     = ramRespValid || plbRespValid;
    assign captureResult = state == stateWaitResp && respValid;
    assign LeafTake      = captureResult && cmdReg == `CMD_UPDATE;   // Leaf consumed

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            Valid             <= 1'b0;
            EvictDataOutValid <= 1'b0;
        end else begin
            EvictDataOutValid <= captureResult && plbRespValid && plbEvict;
            if (captureResult) begin
                Valid <= 1'b1;
            end else if (Valid && OutReady) begin
                Valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (captureResult) begin
            if (ramRespValid) begin
                Hit        <= 1'b1;
                UnInit     <= !ramEntry[`ENTRY_WIDTH-1];
                OldLeafOut <= ramEntry[`LEAF_WIDTH-1:0];
                Evict      <= 1'b0;
                AddrOut    <= addrReg;
            end else begin
                Hit        <= plbHit;
                UnInit     <= plbHit && !plbEntry[`ENTRY_WIDTH-1];
                OldLeafOut <= plbEntry[`LEAF_WIDTH-1:0];
                Evict      <= plbEvict;
                AddrOut    <= plbEvict ? plbEvictAddr : addrReg;
            end
            EvictDataOut <= plbEvictBlock;
            if (cmdReg == `CMD_UPDATE) begin
                NewLeafOut <= NewLeaf;                   // Same leaf the store wrote
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/posMapRam.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posMap_defines.svh"

module posMapRam (
    input  wire                                 Clock,
    input  wire                                 arstN,
    input  wire                                 Enable,
    input  wire                                 Write,
    input  wire [`LOG_FINAL_POSMAP_ENTRIES-1:0] Addr,
    input  wire [`LEAF_WIDTH-1:0]               LeafIn,
    output logic                                RespValid,
    output logic [`ENTRY_WIDTH-1:0]             EntryOut
);

    localparam int entryCount = 1 << `LOG_FINAL_POSMAP_ENTRIES;

    logic [entryCount-1:0]  initBits;                    // Cleared by reset
    logic [`LEAF_WIDTH-1:0] leafMem [entryCount];

    // Control state and initialized flags
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            RespValid <= 1'b0;
            initBits  <= '0;
        end else begin
            RespValid <= Enable;
            if (Enable && Write) begin
                initBits[Addr] <= 1'b1;
            end
        end
    end

    // Leaf storage, read returns the value held before this edge
    always_ff @(posedge Clock) begin
        if (Enable) begin
            EntryOut <= {initBits[Addr], leafMem[Addr]};
            if (Write) begin
                leafMem[Addr] <= LeafIn;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/posMapTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posMap_defines.svh"

module posMapTop (
    input  wire                       Clock,
    input  wire                       arstN,
    input  wire                       CmdValid,
    input  wire [1:0]                 Cmd,
    input  wire [`ADDR_WIDTH-1:0]     AddrIn,
    input  wire                       DInValid,
    input  wire posMapPkg::plbBlock_t DIn,
    input  wire                       OutReady,
    output logic                      CmdReady,
    output logic                      Valid,
    output logic                      Hit,
    output logic                      UnInit,
    output logic [`LEAF_WIDTH-1:0]    OldLeafOut,
    output logic [`LEAF_WIDTH-1:0]    NewLeafOut,
    output logic                      Evict,
    output logic [`ADDR_WIDTH-1:0]    AddrOut,
    output logic                      EvictDataOutValid,
    output posMapPkg::plbBlock_t      EvictDataOut
);

    logic                   leafTake;
    logic [`LEAF_WIDTH-1:0] newLeaf;

    // Random leaf source
    leafRng rng (
        .Clock    (Clock),
        .arstN    (arstN),
        .LeafTake (leafTake),
        .Leaf     (newLeaf)
    );

    posMapPlb posMap (
        .Clock             (Clock),
        .arstN             (arstN),
        .CmdValid          (CmdValid),
        .Cmd               (Cmd),
        .AddrIn            (AddrIn),
        .DInValid          (DInValid),
        .DIn               (DIn),
        .OutReady          (OutReady),
        .NewLeaf           (newLeaf),
        .CmdReady          (CmdReady),
        .LeafTake          (leafTake),
        .Valid             (Valid),
        .Hit               (Hit),
        .UnInit            (UnInit),
        .OldLeafOut        (OldLeafOut),
        .NewLeafOut        (NewLeafOut),
        .Evict             (Evict),
        .AddrOut           (AddrOut),
        .EvictDataOutValid (EvictDataOutValid),
        .EvictDataOut      (EvictDataOut)
    );

endmodule

`default_nettype wire

/* verilog/posMap_defines.svh */
`ifndef POSMAP_DEFINES_SVH
`define POSMAP_DEFINES_SVH

// Address and leaf widths
`define ADDR_WIDTH                10
`define LEAF_WIDTH                8
`define ENTRY_WIDTH               (`LEAF_WIDTH + 1)      // {initialized, leaf}

// PLB geometry
`define LOG_LEAVES_IN_BLOCK       2                      // 4 entries per block
`define BLOCK_WIDTH               ((1 << `LOG_LEAVES_IN_BLOCK) * `ENTRY_WIDTH)
`define LOG_PLB_LINES             3                      // 8 lines

// On-chip position map region
`define FINAL_POSMAP_START        10'h3C0
`define LOG_FINAL_POSMAP_ENTRIES  6

// Command codes
`define CMD_UPDATE                2'd0
`define CMD_READ                  2'd1
`define CMD_REFILL                2'd2
`define CMD_INIT_REFILL           2'd3

`endif
